/* common/clk_gen_regs_pkg.sv */
// --------------------
// register map of the clock generator APB bank
// byte offsets, only word aligned accesses decode
// stored words are the written data ANDed with the field mask
// --------------------
package clk_gen_regs_pkg;

  localparam int APB_ADDR_W = 12;

  // byte offsets
  localparam logic [APB_ADDR_W-1:0] REG_CTL     = 12'h000;
  localparam logic [APB_ADDR_W-1:0] REG_DIV     = 12'h004;
  localparam logic [APB_ADDR_W-1:0] REG_FRAC    = 12'h008;
  localparam logic [APB_ADDR_W-1:0] REG_SS1     = 12'h00C;
  localparam logic [APB_ADDR_W-1:0] REG_SS2     = 12'h010;
  localparam logic [APB_ADDR_W-1:0] REG_SOC     = 12'h014;
  localparam logic [APB_ADDR_W-1:0] REG_PERIPH  = 12'h018;
  localparam logic [APB_ADDR_W-1:0] REG_CLUSTER = 12'h01C;

  // control word fields
  localparam int CTL_LOCK_BIT      = 31;  // read only
  localparam int CTL_PDDP_BIT      = 25;
  localparam int CTL_PD_BIT        = 24;
  localparam int CTL_MODE_LSB      = 16;  // 2 bits
  localparam int CTL_DM_LSB        = 8;   // 6 bits
  localparam int CTL_PLL_RESET_BIT = 1;
  localparam int CTL_BYPASS_BIT    = 0;

  // divider word fields
  localparam int DIV_DN_LSB = 16;  // 11 bits
  localparam int DIV_DP_LSB = 0;   // 3 bits

  // --------------------
  // field masks
  localparam logic [31:0] CTL_MASK = (32'h1 << CTL_PDDP_BIT) | (32'h1 << CTL_PD_BIT) |
                                     (32'h3 << CTL_MODE_LSB) | (32'h3F << CTL_DM_LSB) |
                                     (32'h1 << CTL_PLL_RESET_BIT) | (32'h1 << CTL_BYPASS_BIT);
  localparam logic [31:0] DIV_MASK    = (32'h7FF << DIV_DN_LSB) | (32'h7 << DIV_DP_LSB);
  localparam logic [31:0] FRAC_MASK   = 32'h00FF_FFFF;
  localparam logic [31:0] SSRATE_MASK = 32'h0000_0FFF;
  localparam logic [31:0] SSLOPE_MASK = 32'h00FF_FFFF;
  localparam logic [31:0] CLKDIV_MASK = 32'h0000_03FF;

  // --------------------
  // reset words
  localparam logic [31:0] CTL_RESET_VAL = (32'd1 << CTL_DM_LSB) |     // DM = 1
                                          (32'h1 << CTL_PLL_RESET_BIT) |
                                          (32'h1 << CTL_BYPASS_BIT);
  localparam logic [31:0] DIV_RESET_VAL = (32'd80 << DIV_DN_LSB) | (32'd7 << DIV_DP_LSB);
  localparam logic [31:0] SOC_DIV_RESET     = 32'd10;
  localparam logic [31:0] PERIPH_DIV_RESET  = 32'd20;
  localparam logic [31:0] CLUSTER_DIV_RESET = 32'd30;

endpackage

/* common/clk_gen_cfg_pkg.sv */
// --------------------
// build constants of the clock generator
// SYNC_STAGES must be 2 or more
// lock timer counts reference clock cycles
// --------------------
package clk_gen_cfg_pkg;

  // width of one clock divide ratio, matches the 10 bit register field
  localparam int DIV_W = 10;

  // reference cycles from PLL release to lock
  localparam int LOCK_CYCLES = 64;

  // flops per synchronizer chain
  localparam int SYNC_STAGES = 2;

endpackage

/* pll_regs/apb_pll_regs.sv */
// --------------------
// APB slave bank of the PLL and clock divider settings
// no wait on the bus side beyond one access cycle
// unmapped offsets answer with pslverr, read 0, write nothing
// --------------------
`timescale 1ns/100ps

module apb_pll_regs import clk_gen_regs_pkg::*, clk_gen_cfg_pkg::*; (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  // APB slave
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]           pwdata_i,
  input  logic                  pwrite_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // status and settings
  input  logic                  lock_i,
  output logic                  pd_o,
  output logic                  pll_reset_o,
  output logic                  bypass_o,
  output logic [DIV_W-1:0]      soc_div_o,
  output logic [DIV_W-1:0]      periph_div_o,
  output logic [DIV_W-1:0]      cluster_div_o,
  output logic                  upd_o
);

  typedef enum logic [1:0] {IDLE, ACCESS, DONE} state_e;

  state_e      state_q;
  logic        pready_q, pslverr_q, upd_q;
  logic [31:0] prdata_q;

  // stored, already masked words
  logic [31:0] ctl_q, div_q, frac_q, ss1_q, ss2_q;
  logic [31:0] soc_q, periph_q, cluster_q;

  logic        hit;       // offset is mapped
  logic        clk_hit;   // offset touches clock settings
  logic        wr_en;
  logic [31:0] rd_word;

  // --------------------
  // address decode and read mux
  always_comb begin
    hit     = 1'b1;
    rd_word = '0;
    case (paddr_i)
      REG_CTL: begin
        rd_word               = ctl_q;
        rd_word[CTL_LOCK_BIT] = lock_i;  // live lock status
      end
      REG_DIV:     rd_word = div_q;
      REG_FRAC:    rd_word = frac_q;
      REG_SS1:     rd_word = ss1_q;
      REG_SS2:     rd_word = ss2_q;
      REG_SOC:     rd_word = soc_q;
      REG_PERIPH:  rd_word = periph_q;
      REG_CLUSTER: rd_word = cluster_q;
      default:     hit     = 1'b0;
    endcase
  end

  assign clk_hit = (paddr_i == REG_CTL) || (paddr_i == REG_SOC) ||
                   (paddr_i == REG_PERIPH) || (paddr_i == REG_CLUSTER);
  assign wr_en   = (state_q == ACCESS) && pwrite_i;

  // --------------------
  // access FSM
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q   <= IDLE;
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
      upd_q     <= 1'b0;
    end else begin
      upd_q <= wr_en && clk_hit;  // one cycle, after the regs hold the new word
      case (state_q)
        IDLE: begin
          if (psel_i && penable_i) state_q <= ACCESS;
        end
        ACCESS: begin
          state_q   <= DONE;
          pready_q  <= 1'b1;
          pslverr_q <= !hit;
        end
        DONE: begin
          if (!penable_i) begin  // master closed the transfer
            state_q   <= IDLE;
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // read data, zero on writes and unmapped reads
  always_ff @(posedge HCLK) begin
    if (state_q == ACCESS) prdata_q <= pwrite_i ? '0 : rd_word;
  end

  // --------------------
  // register bank
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ctl_q     <= CTL_RESET_VAL;
      div_q     <= DIV_RESET_VAL;
      frac_q    <= '0;
      ss1_q     <= '0;
      ss2_q     <= '0;
      soc_q     <= SOC_DIV_RESET;
      periph_q  <= PERIPH_DIV_RESET;
      cluster_q <= CLUSTER_DIV_RESET;
    end else if (wr_en) begin
      case (paddr_i)
        REG_CTL:     ctl_q     <= pwdata_i & CTL_MASK;
        REG_DIV:     div_q     <= pwdata_i & DIV_MASK;
        REG_FRAC:    frac_q    <= pwdata_i & FRAC_MASK;
        REG_SS1:     ss1_q     <= pwdata_i & SSRATE_MASK;
        REG_SS2:     ss2_q     <= pwdata_i & SSLOPE_MASK;
        REG_SOC:     soc_q     <= pwdata_i & CLKDIV_MASK;
        REG_PERIPH:  periph_q  <= pwdata_i & CLKDIV_MASK;
        REG_CLUSTER: cluster_q <= pwdata_i & CLKDIV_MASK;
        default:     ;  // unmapped, nothing stored
      endcase
    end
  end

  assign prdata_o  = prdata_q;
  assign pready_o  = pready_q;
  assign pslverr_o = pslverr_q;
  assign upd_o     = upd_q;

  // settings towards the clock side
  assign pd_o          = ctl_q[CTL_PD_BIT];
  assign pll_reset_o   = ctl_q[CTL_PLL_RESET_BIT];
  assign bypass_o      = ctl_q[CTL_BYPASS_BIT];
  assign soc_div_o     = soc_q[DIV_W-1:0];
  assign periph_div_o  = periph_q[DIV_W-1:0];
  assign cluster_div_o = cluster_q[DIV_W-1:0];

endmodule

/* design/cfg_sync.sv */
// --------------------
// HCLK to reference clock transfer of the divider settings
// four phase req/ack, latency of several cycles in both domains
// updates during a transfer collapse into one more transfer
// --------------------
`timescale 1ns/100ps

module cfg_sync import clk_gen_regs_pkg::*, clk_gen_cfg_pkg::*; (
  input  logic             HCLK,
  input  logic             HRESETn,
  input  logic             ref_clk_i,
  // HCLK side
  input  logic             upd_i,
  input  logic             bypass_i,
  input  logic [DIV_W-1:0] soc_div_i,
  input  logic [DIV_W-1:0] periph_div_i,
  input  logic [DIV_W-1:0] cluster_div_i,
  // reference side
  output logic             bypass_o,
  output logic [DIV_W-1:0] soc_div_o,
  output logic [DIV_W-1:0] periph_div_o,
  output logic [DIV_W-1:0] cluster_div_o
);

  // --------------------
  // HCLK side
  logic                   req_q, pend_q;
  logic [SYNC_STAGES-1:0] ack_sync_q;
  logic                   ack_h, start;

  // snapshot, stable while req is up
  logic                   snap_bypass_q;
  logic [DIV_W-1:0]       snap_soc_q, snap_periph_q, snap_cluster_q;

  assign ack_h = ack_sync_q[SYNC_STAGES-1];
  assign start = !req_q && !ack_h && (upd_i || pend_q);  // previous handshake fully closed

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      req_q  <= 1'b0;
      pend_q <= 1'b0;
    end else begin
      if (start) req_q <= 1'b1;
      else if (ack_h) req_q <= 1'b0;  // phase 3
      if (start) pend_q <= 1'b0;
      else if (upd_i) pend_q <= 1'b1;  // resend latest values later
    end
  end

  always_ff @(posedge HCLK) begin
    if (start) begin
      snap_bypass_q  <= bypass_i;
      snap_soc_q     <= soc_div_i;
      snap_periph_q  <= periph_div_i;
      snap_cluster_q <= cluster_div_i;
    end
  end

  // --------------------
  // reference side
  logic [SYNC_STAGES-1:0] ref_rst_q;  // reset sync, async assert
  logic                   ref_rst_n;
  logic [SYNC_STAGES-1:0] req_sync_q;
  logic                   req_r, ack_q;

  always_ff @(posedge ref_clk_i or negedge HRESETn) begin
    if (!HRESETn) ref_rst_q <= '0;
    else ref_rst_q <= {ref_rst_q[SYNC_STAGES-2:0], 1'b1};
  end
  assign ref_rst_n = ref_rst_q[SYNC_STAGES-1];

  assign req_r = req_sync_q[SYNC_STAGES-1];

  always_ff @(posedge ref_clk_i or negedge ref_rst_n) begin
    if (!ref_rst_n) begin
      req_sync_q    <= '0;
      ack_q         <= 1'b0;
      bypass_o      <= 1'b1;  // clocks follow ref until programmed
      soc_div_o     <= DIV_W'(SOC_DIV_RESET);
      periph_div_o  <= DIV_W'(PERIPH_DIV_RESET);
      cluster_div_o <= DIV_W'(CLUSTER_DIV_RESET);
    end else begin
      req_sync_q <= {req_sync_q[SYNC_STAGES-2:0], req_q};
      ack_q      <= req_r;  // ack mirrors req
      if (req_r && !ack_q) begin  // load once per request
        bypass_o      <= snap_bypass_q;
        soc_div_o     <= snap_soc_q;
        periph_div_o  <= snap_periph_q;
        cluster_div_o <= snap_cluster_q;
      end
    end
  end

  // ack back into HCLK
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) ack_sync_q <= '0;
    else ack_sync_q <= {ack_sync_q[SYNC_STAGES-2:0], ack_q};
  end

endmodule

/* design/pll_lock_ctrl.sv */
// --------------------
// stand-in for the analog PLL lock
// lock rises LOCK_CYCLES ref cycles after reset and power down drop
// lock_o in HCLK trails the reference lock by the sync chain
// --------------------
`timescale 1ns/100ps

module pll_lock_ctrl import clk_gen_cfg_pkg::*; (
  input  logic HCLK,
  input  logic HRESETn,
  input  logic ref_clk_i,
  input  logic pll_reset_i,  // HCLK domain
  input  logic pd_i,         // HCLK domain
  output logic lock_ref_o,   // reference domain, gates the dividers
  output logic lock_o        // HCLK domain, register read-back
);

  localparam int CNT_W = $clog2(LOCK_CYCLES);

  logic [SYNC_STAGES-1:0] rst_sync_q, pd_sync_q;
  logic [SYNC_STAGES-1:0] lock_sync_q;
  logic                   halt;
  logic [CNT_W-1:0]       cnt_q;
  logic                   lock_q;

  // either control high keeps the PLL out of lock
  assign halt = rst_sync_q[SYNC_STAGES-1] | pd_sync_q[SYNC_STAGES-1];

  // --------------------
  // reference domain
  always_ff @(posedge ref_clk_i or negedge HRESETn) begin
    if (!HRESETn) begin
      rst_sync_q <= '1;  // PLL held in reset
      pd_sync_q  <= '1;
      cnt_q      <= '0;
      lock_q     <= 1'b0;
    end else begin
      rst_sync_q <= {rst_sync_q[SYNC_STAGES-2:0], pll_reset_i};
      pd_sync_q  <= {pd_sync_q[SYNC_STAGES-2:0], pd_i};
      if (halt) begin
        cnt_q  <= '0;
        lock_q <= 1'b0;  // drop at once
      end else if (!lock_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == CNT_W'(LOCK_CYCLES - 1)) lock_q <= 1'b1;
      end
    end
  end

  assign lock_ref_o = lock_q;

  // --------------------
  // back into HCLK
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) lock_sync_q <= '0;
    else lock_sync_q <= {lock_sync_q[SYNC_STAGES-2:0], lock_q};
  end

  assign lock_o = lock_sync_q[SYNC_STAGES-1];

endmodule

/* design/clk_divider.sv */
// --------------------
// integer clock divider, period div_i input cycles
// odd ratios give one input cycle more low than high
// bypass wins over run, ratios 0 and 1 pass clk_i
// --------------------
`timescale 1ns/100ps

module clk_divider import clk_gen_cfg_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [DIV_W-1:0] div_i,
  input  logic             run_i,     // lock, low holds output low
  input  logic             bypass_i,
  output logic             clk_o
);

  logic [DIV_W-1:0] cnt_q, cnt_nxt;
  logic [DIV_W-1:0] half;
  logic             div_clk_q;
  logic             pass;

  assign half    = div_i >> 1;
  assign cnt_nxt = (cnt_q >= div_i - 1'b1) ? '0 : cnt_q + 1'b1;  // wraps on ratio shrink
  assign pass    = (div_i <= DIV_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      div_clk_q <= 1'b0;
    end else if (!run_i) begin
      cnt_q     <= '0;  // restart phase on next lock
      div_clk_q <= 1'b0;
    end else begin
      cnt_q     <= cnt_nxt;
      div_clk_q <= (cnt_nxt < half);  // high for the first half of the period
    end
  end

  // output select
  always_comb begin
    if (bypass_i) clk_o = clk_i;
    else if (!run_i) clk_o = 1'b0;
    else if (pass) clk_o = clk_i;
    else clk_o = div_clk_q;
  end

endmodule

/* design/clk_gen_top.sv */
// --------------------
// clock generation subsystem, three divided ref clocks
// APB programs ratios, bypass and the lock stand-in
// --------------------
`timescale 1ns/100ps

module clk_gen_top import clk_gen_regs_pkg::*, clk_gen_cfg_pkg::*; (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  // APB slave
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]           pwdata_i,
  input  logic                  pwrite_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // clocks
  input  logic                  ref_clk_i,
  output logic                  soc_clk_o,
  output logic                  periph_clk_o,
  output logic                  cluster_clk_o
);

  // HCLK domain settings
  logic             lock_h, pd, pll_reset, bypass_h, upd;
  logic [DIV_W-1:0] soc_div_h, periph_div_h, cluster_div_h;

  // reference domain settings
  logic             lock_r, bypass_r;
  logic [DIV_W-1:0] soc_div_r, periph_div_r, cluster_div_r;

  apb_pll_regs u_regs (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i), .pwrite_i(pwrite_i),
    .psel_i(psel_i), .penable_i(penable_i),
    .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
    .lock_i(lock_h), .pd_o(pd), .pll_reset_o(pll_reset), .bypass_o(bypass_h),
    .soc_div_o(soc_div_h), .periph_div_o(periph_div_h), .cluster_div_o(cluster_div_h),
    .upd_o(upd)
  );

  cfg_sync u_cfg_sync (
    .HCLK(HCLK), .HRESETn(HRESETn), .ref_clk_i(ref_clk_i),
    .upd_i(upd), .bypass_i(bypass_h),
    .soc_div_i(soc_div_h), .periph_div_i(periph_div_h), .cluster_div_i(cluster_div_h),
    .bypass_o(bypass_r),
    .soc_div_o(soc_div_r), .periph_div_o(periph_div_r), .cluster_div_o(cluster_div_r)
  );

  pll_lock_ctrl u_lock (
    .HCLK(HCLK), .HRESETn(HRESETn), .ref_clk_i(ref_clk_i),
    .pll_reset_i(pll_reset), .pd_i(pd),
    .lock_ref_o(lock_r), .lock_o(lock_h)
  );

  // --------------------
  // output dividers, gated by ref domain lock
  clk_divider u_soc_div (
    .clk_i(ref_clk_i), .rst_ni(HRESETn), .div_i(soc_div_r),
    .run_i(lock_r), .bypass_i(bypass_r), .clk_o(soc_clk_o)
  );

  clk_divider u_periph_div (
    .clk_i(ref_clk_i), .rst_ni(HRESETn), .div_i(periph_div_r),
    .run_i(lock_r), .bypass_i(bypass_r), .clk_o(periph_clk_o)
  );

  clk_divider u_cluster_div (
    .clk_i(ref_clk_i), .rst_ni(HRESETn), .div_i(cluster_div_r),
    .run_i(lock_r), .bypass_i(bypass_r), .clk_o(cluster_clk_o)
  );

endmodule

/* tb/tb_clk_gen.sv */
// --------------------
// testbench of the clock generator with HCLK 20 ns and ref clock 50 ns
// clock periods are checked in whole ns at one output at a time
// the lock stand-in only gates the clocks and never changes a frequency
// --------------------
`timescale 1ns/100ps

module tb_clk_gen;

  localparam int HCLK_HALF   = 10;
  localparam int REF_HALF    = 25;
  localparam int REF_PERIOD  = 2 * REF_HALF;
  localparam int LOCK_REF    = 64;   // ref cycles from release to lock
  localparam int ACK_LIMIT   = 20;   // HCLK cycles to wait for pready
  localparam int READY_WAITS = 2;    // pready two HCLK edges after penable
  localparam int POLL_LIMIT  = 100;  // CTL reads in about 10 us
  localparam int EDGE_LIMIT  = 200;  // HCLK cycles for three clock edges
  localparam int QLEN        = 1024;
  // about eight times the 25 us that the tests take
  localparam int WATCHDOG_NS = 200_000;

  logic        HCLK, HRESETn, ref_clk;
  logic [11:0] paddr;
  logic [31:0] pwdata, prdata;
  logic        pwrite, psel, penable, pready, pslverr;
  logic        soc_clk, periph_clk, cluster_clk;

  logic [31:0] model [8];  // raw words as written
  logic        lock_exp;
  int          fail_count, test_count, errors_before;

  // --------------------
  // check ring filled by the tests and drained by the compare process
  logic [31:0] got_a [QLEN];
  logic [31:0] exp_a [QLEN];
  string       what_a [QLEN];
  int          wr_idx, rd_idx, check_count, error_count;

  // clock measurement on the selected output
  int          meas_sel;
  logic        meas_clk;
  int          meas_edges;
  realtime     meas_last, meas_prev;

  clk_gen_top i_clk_gen_top (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .paddr_i(paddr), .pwdata_i(pwdata), .pwrite_i(pwrite),
    .psel_i(psel), .penable_i(penable),
    .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .ref_clk_i(ref_clk),
    .soc_clk_o(soc_clk), .periph_clk_o(periph_clk), .cluster_clk_o(cluster_clk)
  );

  initial begin
    HCLK = 1'b0;
    forever #(HCLK_HALF) HCLK = ~HCLK;
  end

  initial begin
    ref_clk = 1'b0;  // rising edges never meet HCLK edges
    forever #(REF_HALF) ref_clk = ~ref_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  // --------------------
  // measurement process
  assign meas_clk = (meas_sel == 0) ? soc_clk : (meas_sel == 1) ? periph_clk : cluster_clk;

  always @(posedge meas_clk) begin
    meas_prev  = meas_last;
    meas_last  = $realtime;
    meas_edges = meas_edges + 1;
  end

  // compare process
  always @(negedge HCLK) begin
    while (rd_idx != wr_idx) begin
      check_count++;
      if (got_a[rd_idx % QLEN] !== exp_a[rd_idx % QLEN]) begin
        error_count++;
        $display("** Error at %0d ns: %s is %h, expected %h", $time,
                 what_a[rd_idx % QLEN], got_a[rd_idx % QLEN], exp_a[rd_idx % QLEN]);
      end
      rd_idx++;
    end
  end

  // --------------------
  // reference model of the read word
  function automatic logic [31:0] field_mask(input int idx);
    case (idx)
      0:       return 32'h0303_3F03;  // PDDP PD MODE DM PLL_RESET BYPASS
      1:       return 32'h07FF_0007;  // DN and DP
      2, 4:    return 32'h00FF_FFFF;  // FRAC, SSLOPE
      3:       return 32'h0000_0FFF;  // SSRATE
      default: return 32'h0000_03FF;  // clock ratios
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input int idx, input logic lock);
    logic [31:0] word;
    word = model[idx] & field_mask(idx);
    if (idx == 0) word[31] = lock;  // lock status on CTL only
    return word;
  endfunction

  function automatic string clock_name(input int sel);
    case (sel)
      0:       return "soc_clk_o";
      1:       return "periph_clk_o";
      default: return "cluster_clk_o";
    endcase
  endfunction

  task automatic post_check(input string what, input logic [31:0] got, input logic [31:0] exp);
    got_a[wr_idx % QLEN]  = got;
    exp_a[wr_idx % QLEN]  = exp;
    what_a[wr_idx % QLEN] = what;
    wr_idx++;
  endtask

  task automatic report_failure(input string text);
    fail_count++;
    $display("Failure at %0d ns: %s", $time, text);
  endtask

  // one APB transfer that waits for pready with a limit
  task automatic access_reg(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waits;
    @(posedge HCLK);
    paddr   <= addr;
    pwdata  <= wdata;
    pwrite  <= wr;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge HCLK);
    penable <= 1'b1;
    waits = 0;
    @(negedge HCLK);
    while (!pready && waits < ACK_LIMIT) begin
      @(negedge HCLK);
      waits++;
    end
    if (!pready) report_failure($sformatf("no pready on access to offset %h", addr));
    else post_check($sformatf("pready delay on %h", addr), 32'(waits), 32'(READY_WAITS));
    rdata = prdata;  // sampled mid cycle
    err   = pslverr;
    @(posedge HCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_reg(input int idx, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    access_reg(12'(4 * idx), 1'b1, data, rdata, err);
    post_check($sformatf("pslverr on write to %h", 4 * idx), {31'b0, err}, 32'h0);
    model[idx] = data;
  endtask

  task automatic check_reg(input int idx);
    logic [31:0] rdata;
    logic        err;
    access_reg(12'(4 * idx), 1'b0, 32'h0, rdata, err);
    post_check($sformatf("read of offset %h", 4 * idx), rdata, expected_read(idx, lock_exp));
    post_check($sformatf("pslverr on read of %h", 4 * idx), {31'b0, err}, 32'h0);
  endtask

  // polls CTL until lock equals want
  // lock must stay 0 before quiet_until
  task automatic poll_lock(input logic want, input realtime quiet_until);
    logic [31:0] word;
    logic        err;
    int          polls;
    polls = 0;
    do begin
      access_reg(12'h000, 1'b0, 32'h0, word, err);
      polls++;
      if ($realtime < quiet_until) post_check("CTL before lock time", word, expected_read(0, 1'b0));
      else post_check("CTL fields while polling", {1'b0, word[30:0]}, expected_read(0, 1'b0));
    end while (word[31] !== want && polls < POLL_LIMIT);
    if (word[31] !== want)
      report_failure($sformatf("lock bit did not read %0b within %0d polls", want, POLL_LIMIT));
    else lock_exp = want;
  endtask

  task automatic check_period(input int sel, input int ratio);
    int start, waits, period;
    meas_sel = sel;
    @(negedge HCLK);  // a select change can fake one edge
    start = meas_edges;
    waits = 0;
    while (meas_edges < start + 3 && waits < EDGE_LIMIT) begin
      @(negedge HCLK);
      waits++;
    end
    if (meas_edges < start + 3) begin
      report_failure($sformatf("%s shows no running clock", clock_name(sel)));
    end else begin
      period = $rtoi(meas_last - meas_prev + 0.5);
      post_check($sformatf("%s period in ns", clock_name(sel)), 32'(period),
                 32'(ratio * REF_PERIOD));
    end
  endtask

  task automatic check_stopped(input int sel);
    int   start;
    logic high;
    meas_sel = sel;
    @(negedge HCLK);
    start = meas_edges;
    high  = 1'b0;
    repeat (40) begin  // several divided periods
      @(negedge HCLK);
      if (meas_clk !== 1'b0) high = 1'b1;
    end
    post_check($sformatf("%s high while stopped", clock_name(sel)), {31'b0, high}, 32'h0);
    post_check($sformatf("%s edges while stopped", clock_name(sel)), 32'(meas_edges - start),
               32'h0);
  endtask

  task automatic end_test(input string name);
    while (rd_idx != wr_idx) @(negedge HCLK);  // let the compare process catch up
    test_count++;
    $display("test %0d %s: %s, %0d errors", test_count, name,
             (error_count + fail_count == errors_before) ? "passed" : "failed",
             error_count + fail_count - errors_before);
    errors_before = error_count + fail_count;
  endtask

  // --------------------
  // test sequence
  initial begin
    logic [31:0] word, data;
    logic [11:0] addr;
    logic        err;
    int          idx;
    realtime     quiet_until;
    void'($urandom(97516));
    HRESETn  = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    pwrite   = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    lock_exp = 1'b0;
    meas_sel = 0;
    model    = '{32'h0000_0103, 32'h0050_0007, 32'h0, 32'h0, 32'h0, 32'd10, 32'd20, 32'd30};
    repeat (10) @(posedge HCLK);
    HRESETn <= 1'b1;
    repeat (2) @(posedge HCLK);

    for (idx = 0; idx < 8; idx++) check_reg(idx);
    end_test("reset values");

    repeat (4) begin
      for (idx = 0; idx < 8; idx++) begin
        data = $urandom;
        if (idx == 0) data[1] = 1'b1;  // PLL held in reset so lock stays 0
        write_reg(idx, data);
        check_reg(idx);
      end
    end
    repeat (4) begin
      addr = 12'h020 + 12'(4 * ($urandom % 1016));  // word aligned above the map
      access_reg(addr, 1'b1, $urandom, word, err);
      post_check($sformatf("pslverr on write to %h", addr), {31'b0, err}, 32'h1);
      access_reg(addr, 1'b0, 32'h0, word, err);
      post_check($sformatf("read of unmapped %h", addr), word, 32'h0);
      post_check($sformatf("pslverr on read of %h", addr), {31'b0, err}, 32'h1);
    end
    for (idx = 0; idx < 8; idx++) check_reg(idx);  // nothing changed
    end_test("register read-back");

    write_reg(0, 32'h0000_0103);  // bypass and PLL reset set
    repeat (40) @(posedge ref_clk);
    check_period(0, 1);
    end_test("bypass period");

    write_reg(0, 32'h0000_0100);  // bypass and PLL reset cleared
    quiet_until = $realtime + LOCK_REF * REF_PERIOD;
    poll_lock(1'b1, quiet_until);
    end_test("lock");

    write_reg(5, 32'd3);
    write_reg(6, 32'd4);
    write_reg(7, 32'd7);
    repeat (40) @(posedge ref_clk);  // transfer into the ref domain
    check_period(0, 3);
    check_period(1, 4);
    check_period(2, 7);
    for (idx = 5; idx < 8; idx++) check_reg(idx);
    end_test("divided periods");

    write_reg(0, 32'h0100_0100);  // power down
    poll_lock(1'b0, 0.0);
    for (idx = 0; idx < 3; idx++) check_stopped(idx);
    write_reg(0, 32'h0000_0100);
    quiet_until = $realtime + LOCK_REF * REF_PERIOD;
    poll_lock(1'b1, quiet_until);
    check_period(0, 3);
    check_period(1, 4);
    check_period(2, 7);
    end_test("power down");

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count + fail_count,
             error_count + fail_count);
    if (error_count + fail_count == 0) $display("Everything OK");
    else $display("Something failed");
    $finish;
  end

endmodule

/* clk_gen_top.f */
common/clk_gen_regs_pkg.sv
common/clk_gen_cfg_pkg.sv
pll_regs/apb_pll_regs.sv
design/cfg_sync.sv
design/pll_lock_ctrl.sv
design/clk_divider.sv
design/clk_gen_top.sv
tb/tb_clk_gen.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds tb_clk_gen with Verilator, runs it and decides pass or fail
# by searching the log for the pass line.
set -u
cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BIN=Vtb_clk_gen
LOG=sim.log

verilator --binary --timing -j 0 \
  --top-module tb_clk_gen \
  -Mdir "$OBJ_DIR" -o "$BIN" \
  -f clk_gen_top.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

"./$OBJ_DIR/$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail, see $LOG"
exit 1
